// File: common/emu_defines.svh
`ifndef EMU_DEFINES_SVH
`define EMU_DEFINES_SVH

// Request channels areq, wreq, breq, rreq.
`define EMU_REQ_COUNT 4

// Response channels bresp, rresp.
`define EMU_RESP_COUNT 2

// Largest step burst is 2**16-1 target cycles.
`define EMU_STEP_WIDTH 16

// Target cycle and stall counters wrap at this width.
`define EMU_CYCLE_WIDTH 32

`endif

// File: common/emu_pkg.sv
`include "emu_defines.svh"

package emu_pkg;

    // Bit order areq, wreq, breq, rreq from bit 0.
    typedef logic [`EMU_REQ_COUNT-1:0] req_vec_t;

    // Bit 0 is bresp, bit 1 is rresp.
    typedef logic [`EMU_RESP_COUNT-1:0] resp_vec_t;

    // Target cycles in one step burst.
    typedef logic [`EMU_STEP_WIDTH-1:0] step_cnt_t;

    typedef logic [`EMU_CYCLE_WIDTH-1:0] cycle_cnt_t;

    // Scheduler modes.
    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_STEP,
        S_DRAIN
    } sched_state_t;

endpackage

// File: common/sched_if.sv
interface sched_if;

    logic active;       // Tokens offered this cycle.
    logic partial;      // Some channel already done.
    logic target_tick;  // Target cycle ends.
    logic last_step;    // One step left in the burst.

    modport fsm (
        output active,
        input  partial,
        input  target_tick,
        input  last_step
    );

    modport tracker (
        input  active,
        output partial,
        output target_tick
    );

    modport counter (
        input  active,
        input  target_tick,
        output last_step
    );

endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the scheduler testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module emu_clock_ctrl_tb -f verilog.f -o sim_emu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_emu 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

// File: source/cycle_counter.sv
module cycle_counter import emu_pkg::*; (
    input  logic       host_clk,
    input  logic       tk_rst_fire,
    input  logic       step_load,
    input  step_cnt_t  step_count,
    output cycle_cnt_t target_cycle,
    output cycle_cnt_t stall_cycles,
    sched_if.counter   sched
);

    step_cnt_t  step_left;
    cycle_cnt_t tick_cnt;
    cycle_cnt_t stall_cnt;
    logic       stalled;

    // Offering tokens without closing the cycle.
    assign stalled = sched.active && !sched.target_tick;

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            tick_cnt <= '0;
        end else if (sched.target_tick) begin
            tick_cnt <= tick_cnt + 1'b1;    // Wraps.
        end
    end

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            stall_cnt <= '0;
        end else if (stalled) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    // Step down-counter. Free run ticks leave it at zero.
    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            step_left <= '0;
        end else if (step_load) begin
            step_left <= step_count;
        end else if (sched.target_tick && (step_left != '0)) begin
            step_left <= step_left - 1'b1;
        end
    end

    assign sched.last_step = (step_left == step_cnt_t'(1));

    assign target_cycle = tick_cnt;
    assign stall_cycles = stall_cnt;

endmodule

// File: source/emu_clock_ctrl.sv
module emu_clock_ctrl import emu_pkg::*; (
    input  logic       host_clk,
    input  logic       tk_rst_fire,
    input  logic       run_mode,
    input  logic       step_req,
    input  step_cnt_t  step_count,
    input  req_vec_t   req_ready,
    input  resp_vec_t  resp_valid,
    output req_vec_t   req_valid,
    output resp_vec_t  resp_ready,
    output logic       target_tick,
    output cycle_cnt_t target_cycle,
    output cycle_cnt_t stall_cycles,
    output logic       idle
);

    logic step_load;

    sched_if sched ();

    step_fsm u_step_fsm (
        .host_clk    (host_clk),
        .tk_rst_fire (tk_rst_fire),
        .run_mode    (run_mode),
        .step_req    (step_req),
        .step_count  (step_count),
        .step_load   (step_load),
        .idle        (idle),
        .sched       (sched.fsm)
    );

    cycle_counter u_cycle_counter (
        .host_clk     (host_clk),
        .tk_rst_fire  (tk_rst_fire),
        .step_load    (step_load),
        .step_count   (step_count),
        .target_cycle (target_cycle),
        .stall_cycles (stall_cycles),
        .sched        (sched.counter)
    );

    token_tracker u_token_tracker (
        .host_clk    (host_clk),
        .tk_rst_fire (tk_rst_fire),
        .req_ready   (req_ready),
        .req_valid   (req_valid),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .sched       (sched.tracker)
    );

    // Enable strobe in place of a gated target clock.
    assign target_tick = sched.target_tick;

endmodule

// File: source/step_fsm.sv
module step_fsm import emu_pkg::*; (
    input  logic      host_clk,
    input  logic      tk_rst_fire,
    input  logic      run_mode,
    input  logic      step_req,
    input  step_cnt_t step_count,
    output logic      step_load,
    output logic      idle,
    sched_if.fsm      sched
);

    sched_state_t state;
    sched_state_t state_next;
    logic         step_accept;

    // A zero count is no burst at all.
    assign step_accept = (state == S_IDLE) && step_req && (step_count != '0);

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (step_accept) begin
                    state_next = S_STEP;
                end else if (run_mode) begin
                    state_next = S_RUN;
                end
            end
            S_RUN: begin
                // Half-exchanged cycle must be finished first.
                if (!run_mode) begin
                    state_next = sched.partial ? S_DRAIN : S_IDLE;
                end
            end
            S_STEP: begin
                if (sched.target_tick && sched.last_step) begin
                    state_next = S_IDLE;
                end
            end
            S_DRAIN: begin
                if (sched.target_tick) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign step_load    = step_accept;      // Loads the down-counter.
    assign idle         = (state == S_IDLE);
    assign sched.active = (state != S_IDLE);

endmodule

// File: token_tracker/token_tracker.sv
`include "emu_defines.svh"

module token_tracker import emu_pkg::*; (
    input  logic      host_clk,
    input  logic      tk_rst_fire,
    input  req_vec_t  req_ready,
    output req_vec_t  req_valid,
    input  resp_vec_t resp_valid,
    output resp_vec_t resp_ready,
    sched_if.tracker  sched
);

    localparam int REQ_COUNT  = `EMU_REQ_COUNT;
    localparam int CHAN_COUNT = `EMU_REQ_COUNT + `EMU_RESP_COUNT;

    // Requests in the low bits, responses above.
    logic [CHAN_COUNT-1:0] chan_done;
    logic [CHAN_COUNT-1:0] chan_offer;
    logic [CHAN_COUNT-1:0] chan_peer;
    logic [CHAN_COUNT-1:0] chan_fire;
    logic                  all_done;

    // Our side of each token: valid for requests, ready for responses.
    assign chan_offer = {CHAN_COUNT{sched.active}} & ~chan_done;

    // The backend's side of each token.
    assign chan_peer = {resp_valid, req_ready};

    assign chan_fire = chan_offer & chan_peer;

    assign req_valid  = chan_offer[REQ_COUNT-1:0];
    assign resp_ready = chan_offer[CHAN_COUNT-1:REQ_COUNT];

    // Every channel fired now or earlier in this target cycle.
    assign all_done = &(chan_fire | chan_done);

    assign sched.target_tick = sched.active && all_done;
    assign sched.partial     = |chan_done;

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire || sched.target_tick) begin
            chan_done <= '0;    // New token round.
        end else begin
            chan_done <= chan_done | chan_fire;
        end
    end

endmodule

// File: verification/emu_clock_ctrl_tb.sv
module emu_clock_ctrl_tb import emu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 4;
    localparam int          RUN_CYCLES   = 300;
    localparam int          DROP_TRIES   = 20;
    localparam int          DROP_CYCLES  = 40;
    localparam int          STEP_CYCLES  = 200;
    localparam int          STALL_CYCLES = 400;
    localparam int          STIM_CYCLES  = RESET_CYCLES + RUN_CYCLES
                                           + DROP_TRIES * DROP_CYCLES
                                           + STEP_CYCLES + STALL_CYCLES;
    localparam int          IDLE_LIMIT   = 600;
    localparam int unsigned SEED         = 32'h487d7e8c;
    localparam int          REQS         = $bits(req_vec_t);
    localparam int          CHANS        = $bits(req_vec_t) + $bits(resp_vec_t);

    logic       host_clk = 1'b0;
    logic       tk_rst_fire;
    logic       run_mode;
    logic       step_req;
    step_cnt_t  step_count;
    logic       slow;
    req_vec_t   req_ready;
    resp_vec_t  resp_valid;
    req_vec_t   req_valid;
    resp_vec_t  resp_ready;
    logic       target_tick;
    cycle_cnt_t target_cycle;
    cycle_cnt_t stall_cycles;
    logic       idle;

    // Reference model state.
    logic [CHANS-1:0] flags;
    logic [CHANS-1:0] fire;
    logic             exp_tick;
    logic             exp_idle;
    req_vec_t         exp_req_valid;
    resp_vec_t        exp_resp_ready;
    logic             run_on;
    logic             draining;
    logic             in_burst;
    step_cnt_t        burst_left;
    cycle_cnt_t       tick_count;
    cycle_cnt_t       stall_count;
    int               stall_run;
    logic             rst_d = 1'b0;
    logic             clean_drop_seen;
    logic             partial_drop_seen;
    logic             long_stall_seen;
    logic             burst_seen;

    always #(CLK_PERIOD / 2) host_clk = ~host_clk;

    emu_clock_ctrl dut (
        .host_clk     (host_clk),
        .tk_rst_fire  (tk_rst_fire),
        .run_mode     (run_mode),
        .step_req     (step_req),
        .step_count   (step_count),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .req_valid    (req_valid),
        .resp_ready   (resp_ready),
        .target_tick  (target_tick),
        .target_cycle (target_cycle),
        .stall_cycles (stall_cycles),
        .idle         (idle)
    );

    token_backend_model backend (
        .host_clk    (host_clk),
        .tk_rst_fire (tk_rst_fire),
        .slow        (slow),
        .resp_ready  (resp_ready),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid)
    );

    task automatic end_in_failure();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic mismatch_error(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("MISMATCH time=%0t signal=%s dut=0x%0h expected=0x%0h", $time, name, got, exp);
        end_in_failure();
    endtask

    task automatic fail_because(input string what);
        $display("ERROR at %0t: %s", $time, what);
        end_in_failure();
    endtask

    // Port fires with the responses in the upper bits.
    assign fire           = {resp_valid & resp_ready, req_valid & req_ready};
    assign exp_idle       = !(run_on || draining || in_burst);
    assign exp_tick       = !exp_idle && (&(flags | fire));
    assign exp_req_valid  = exp_idle ? '0 : ~flags[REQS-1:0];
    assign exp_resp_ready = exp_idle ? '0 : ~flags[CHANS-1:REQS];

    always @(posedge host_clk) begin
        rst_d <= tk_rst_fire;
        if (tk_rst_fire) begin
            flags             <= '0;
            run_on            <= 1'b0;
            draining          <= 1'b0;
            in_burst          <= 1'b0;
            burst_left        <= '0;
            tick_count        <= '0;
            stall_count       <= '0;
            stall_run         <= 0;
            clean_drop_seen   <= 1'b0;
            partial_drop_seen <= 1'b0;
            long_stall_seen   <= 1'b0;
            burst_seen        <= 1'b0;
        end else begin
            flags <= exp_tick ? '0 : (flags | fire);
            if (exp_tick) begin
                tick_count <= tick_count + 1'b1;
            end
            if (!exp_idle && !exp_tick) begin
                stall_count <= stall_count + 1'b1;
                stall_run   <= stall_run + 1;
            end else begin
                stall_run <= 0;
            end
            if (stall_run == 16) begin
                long_stall_seen <= 1'b1;
            end
            if (exp_idle && step_req && (step_count != '0)) begin
                in_burst   <= 1'b1;
                burst_left <= step_count;
            end else if (exp_idle && run_mode) begin
                run_on <= 1'b1;
            end
            // Falling run_mode drains only a cycle that is partly exchanged.
            if (run_on && !run_mode) begin
                run_on   <= 1'b0;
                draining <= (flags != '0);
                if (flags == '0) begin
                    clean_drop_seen <= 1'b1;
                end else begin
                    partial_drop_seen <= 1'b1;
                end
            end
            if (draining && exp_tick) begin
                draining <= 1'b0;
            end
            if (in_burst && exp_tick) begin
                burst_left <= burst_left - 1'b1;
                if (burst_left == step_cnt_t'(1)) begin
                    in_burst   <= 1'b0;
                    burst_seen <= 1'b1;
                end
            end
        end
    end

    // Reset values, during reset and one cycle after.
    a_reset_idle: assert property (@(posedge host_clk) rst_d |-> idle)
        else mismatch_error("idle", 32'($sampled(idle)), 32'd1);
    a_reset_req_valid: assert property (@(posedge host_clk) rst_d |-> (req_valid == '0))
        else mismatch_error("req_valid", 32'($sampled(req_valid)), 32'd0);
    a_reset_resp_ready: assert property (@(posedge host_clk) rst_d |-> (resp_ready == '0))
        else mismatch_error("resp_ready", 32'($sampled(resp_ready)), 32'd0);
    a_reset_tick: assert property (@(posedge host_clk) rst_d |-> !target_tick)
        else mismatch_error("target_tick", 32'($sampled(target_tick)), 32'd0);
    a_reset_cycle: assert property (@(posedge host_clk) rst_d |-> (target_cycle == '0))
        else mismatch_error("target_cycle", $sampled(target_cycle), 32'd0);
    a_reset_stall: assert property (@(posedge host_clk) rst_d |-> (stall_cycles == '0))
        else mismatch_error("stall_cycles", $sampled(stall_cycles), 32'd0);

    a_tick: assert property (@(posedge host_clk) disable iff (tk_rst_fire)
        target_tick == exp_tick)
        else mismatch_error("target_tick", 32'($sampled(target_tick)), 32'($sampled(exp_tick)));

    a_req_valid: assert property (@(posedge host_clk) disable iff (tk_rst_fire)
        req_valid == exp_req_valid)
        else mismatch_error("req_valid", 32'($sampled(req_valid)),
                            32'($sampled(exp_req_valid)));

    a_resp_ready: assert property (@(posedge host_clk) disable iff (tk_rst_fire)
        resp_ready == exp_resp_ready)
        else mismatch_error("resp_ready", 32'($sampled(resp_ready)),
                            32'($sampled(exp_resp_ready)));

    a_idle: assert property (@(posedge host_clk) disable iff (tk_rst_fire)
        idle == exp_idle)
        else mismatch_error("idle", 32'($sampled(idle)), 32'($sampled(exp_idle)));

    a_target_cycle: assert property (@(posedge host_clk) disable iff (tk_rst_fire)
        target_cycle == tick_count)
        else mismatch_error("target_cycle", $sampled(target_cycle), $sampled(tick_count));

    a_stall: assert property (@(posedge host_clk) disable iff (tk_rst_fire)
        stall_cycles == stall_count)
        else mismatch_error("stall_cycles", $sampled(stall_cycles), $sampled(stall_count));

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge host_clk);
        while (!idle) begin
            if (waited == IDLE_LIMIT) begin
                fail_because("scheduler did not return to idle in time");
            end else begin
                waited++;
                @(negedge host_clk);
            end
        end
    endtask

    task automatic run_step_burst(input step_cnt_t n);
        @(posedge host_clk);
        step_req   <= 1'b1;
        step_count <= n;
        @(posedge host_clk);
        step_req <= 1'b0;
        wait_idle();
    endtask

    initial begin
        #(20 * STIM_CYCLES * CLK_PERIOD);
        fail_because("watchdog expired before the stimulus finished");
    end

    initial begin
        void'($urandom(SEED));
        tk_rst_fire = 1'b1;
        run_mode    = 1'b0;
        step_req    = 1'b0;
        step_count  = '0;
        slow        = 1'b0;
        repeat (RESET_CYCLES) @(posedge host_clk);
        tk_rst_fire <= 1'b0;

        @(posedge host_clk);
        run_mode <= 1'b1;
        repeat (RUN_CYCLES) @(posedge host_clk);
        run_mode <= 1'b0;
        wait_idle();

        // Drop run_mode at random points until both drain cases were hit.
        for (int t = 0; t < DROP_TRIES && !(clean_drop_seen && partial_drop_seen); t++) begin
            @(posedge host_clk);
            slow     <= t[0];
            run_mode <= 1'b1;
            repeat ($urandom_range(3, 20)) @(posedge host_clk);
            run_mode <= 1'b0;
            wait_idle();
        end
        @(posedge host_clk);
        slow <= 1'b0;

        run_step_burst(step_cnt_t'(1));
        run_step_burst(step_cnt_t'(5));
        run_step_burst('0);

        // Requests during a burst must not change its length.
        @(posedge host_clk);
        step_req   <= 1'b1;
        step_count <= step_cnt_t'(5);
        @(posedge host_clk);
        step_req <= 1'b0;
        repeat (2) @(posedge host_clk);
        step_req   <= 1'b1;
        step_count <= step_cnt_t'(9);
        run_mode   <= 1'b1;
        @(posedge host_clk);
        step_req <= 1'b0;
        run_mode <= 1'b0;
        wait_idle();

        @(posedge host_clk);
        slow     <= 1'b1;
        run_mode <= 1'b1;
        repeat (STALL_CYCLES) @(posedge host_clk);
        run_mode <= 1'b0;
        wait_idle();
        repeat (2) @(posedge host_clk);

        if (clean_drop_seen && partial_drop_seen && long_stall_seen && burst_seen) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_because("stimulus did not reach every drain, stall and step case");
        end
    end

endmodule

// File: verification/token_backend_model.sv
module token_backend_model import emu_pkg::*; (
    input  logic      host_clk,
    input  logic      tk_rst_fire,
    input  logic      slow,
    input  resp_vec_t resp_ready,
    output req_vec_t  req_ready,
    output resp_vec_t resp_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    req_vec_t  ready_q = '0;
    resp_vec_t valid_q = '0;

    // Dense side answers about 3 of 4 cycles, sparse side 1 of 16.
    function automatic logic coin(input logic sparse);
        logic [3:0] roll;
        roll = 4'($urandom);
        if (sparse) begin
            return (roll == 4'd0);
        end
        return (roll < 4'd12);
    endfunction

    always @(posedge host_clk) begin
        if (tk_rst_fire) begin
            ready_q <= '0;
            valid_q <= '0;
        end else begin
            // Request readies may come and go freely.
            for (int i = 0; i < $bits(req_vec_t); i++) begin
                ready_q[i] <= coin(slow);
            end
            for (int j = 0; j < $bits(resp_vec_t); j++) begin
                if (valid_q[j] && !resp_ready[j]) begin
                    valid_q[j] <= 1'b1;     // Held until the token fires.
                end else begin
                    valid_q[j] <= coin(slow);
                end
            end
        end
    end

    assign req_ready  = ready_q;
    assign resp_valid = valid_q;

endmodule

// File: verilog.f
+incdir+common
common/emu_pkg.sv
common/sched_if.sv
source/step_fsm.sv
source/cycle_counter.sv
token_tracker/token_tracker.sv
source/emu_clock_ctrl.sv
verification/token_backend_model.sv
verification/emu_clock_ctrl_tb.sv
